//--- verilog/dot11_tx_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared widths and constants of the 6 Mbps OFDM transmit baseband
// PLCP header word union and the sequencing phase enumeration
//////////////////////////////////////////////////////////////////////
package dot11_tx_pkg;

    // Sample memory port
    parameter int MEM_WORD_W = 64;
    parameter int MEM_ADDR_W = 10;

    // Output sample component width
    parameter int IQ_W = 16;

    // Scrambler state width, x^7 + x^4 + 1
    parameter int SCRAM_W = 7;

    // BPSK, rate 1/2
    parameter int N_DBPS = 24;
    parameter int N_CBPS = 2 * N_DBPS;
    parameter int N_SC   = 64;

    // Unit amplitude, the negative unit is its two's complement
    parameter logic [IQ_W-1:0] PILOT_AMP = 16'h4000;

    // DATA field parts around the PSDU
    parameter int SERVICE_BITS = 16;
    parameter int TAIL_BITS    = 6;

    // SIGNAL layout, rate sits in the low nibble
    typedef struct packed {
        logic [45:0] rest;
        logic        parity;
        logic [11:0] length;
        logic        reserved;
        logic [3:0]  rate;
    } plcp_sig_t;

    // Word 0 is read bit by bit for SIGNAL and by field for the length
    typedef union packed {
        logic [MEM_WORD_W-1:0] raw;
        plcp_sig_t             sig;
    } plcp_word_u;

    typedef enum logic [2:0] {
        IDLE,
        FETCH_HDR,
        SIGNAL_ENC,
        DATA_ENC,
        MAP_OUT,
        DONE
    } tx_phase_e;

endpackage

//--- verilog/tx_ctrl_fsm.sv
//////////////////////////////////////////////////////////////////////
// Packet and symbol sequencing FSM
// Header length latch, memory word address, start and done pulses
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tx_ctrl_fsm
    import dot11_tx_pkg::*;
#(
    parameter int MEM_ADDR_W = dot11_tx_pkg::MEM_ADDR_W
) (
    input  logic                  clk,
    input  logic                  reset1,
    input  logic                  tx_start_i,
    input  plcp_word_u            hdr_i,
    input  logic                  bit_last_i,
    input  logic                  sc_last_i,
    input  logic                  out_accept_i,
    input  logic [14:0]           psdu_bit_cnt_i,
    output tx_phase_e             phase_o,
    output logic [14:0]           psdu_bits_o,
    output logic [MEM_ADDR_W-1:0] mem_addr_o,
    output logic                  tx_started_o,
    output logic                  tx_done_o
);

    logic [15:0] data_bits_total;
    logic        more_data;
    logic [14:0] word_off;

    // SERVICE + PSDU + tail, pad is whatever fills the last symbol
    assign data_bits_total = 16'(SERVICE_BITS) + {1'b0, psdu_bits_o} + 16'(TAIL_BITS);
    assign more_data       = {1'b0, psdu_bit_cnt_i} < data_bits_total;

    // Offset of the bit after the current one, relative to the PSDU start
    assign word_off = psdu_bit_cnt_i - 15'(SERVICE_BITS - 1);

    //////////////////////////////////////////////////////////////////////
    // Phase sequencing
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset1) begin
            phase_o      <= IDLE;
            psdu_bits_o  <= '0;
            mem_addr_o   <= '0;
            tx_started_o <= 1'b0;
            tx_done_o    <= 1'b0;
        end else begin
            tx_started_o <= 1'b0;
            tx_done_o    <= 1'b0;

            // Word 0 in IDLE and SIGNAL, then the word of the next bit
            // is requested one cycle ahead so it lands at the bit boundary
            if (phase_o == IDLE || psdu_bit_cnt_i < 15'(SERVICE_BITS - 1)) begin
                mem_addr_o <= '0;
            end else begin
                mem_addr_o <= MEM_ADDR_W'(word_off[14:6]) + 1'b1;
            end

            // Header word is on the bus throughout SIGNAL
            if (phase_o == SIGNAL_ENC) begin
                psdu_bits_o <= {hdr_i.sig.length, 3'b000};
            end

            case (phase_o)
                IDLE: begin
                    if (tx_start_i) begin
                        phase_o <= FETCH_HDR;
                    end
                end
                FETCH_HDR: begin
                    // Word 0 arrives on the next edge
                    phase_o      <= SIGNAL_ENC;
                    tx_started_o <= 1'b1;
                end
                SIGNAL_ENC, DATA_ENC: begin
                    if (bit_last_i) begin
                        phase_o <= MAP_OUT;
                    end
                end
                MAP_OUT: begin
                    // Last sample of the symbol taken by the sink
                    if (out_accept_i && sc_last_i) begin
                        if (more_data) begin
                            phase_o <= DATA_ENC;
                        end else begin
                            phase_o   <= DONE;
                            tx_done_o <= 1'b1;
                        end
                    end
                end
                default: begin
                    phase_o <= IDLE;
                end
            endcase
        end
    end

endmodule

//--- verilog/symbol_counter.sv
//////////////////////////////////////////////////////////////////////
// Coded bit, subcarrier index and DATA field bit counters
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module symbol_counter
    import dot11_tx_pkg::*;
(
    input  logic        clk,
    input  logic        reset1,
    input  tx_phase_e   phase_i,
    input  logic        out_accept_i,
    output logic [5:0]  bit_idx_o,
    output logic [5:0]  sc_idx_o,
    output logic        bit_last_o,
    output logic        sc_last_o,
    output logic [14:0] psdu_bit_cnt_o
);

    logic enc_phase;

    assign enc_phase  = (phase_i == SIGNAL_ENC) || (phase_i == DATA_ENC);
    assign bit_last_o = enc_phase && (bit_idx_o == 6'(N_CBPS - 1));
    assign sc_last_o  = sc_idx_o == 6'(N_SC - 1);

    always_ff @(posedge clk) begin
        if (reset1) begin
            bit_idx_o      <= '0;
            sc_idx_o       <= '0;
            psdu_bit_cnt_o <= '0;
        end else begin
            // One coded bit per cycle, A then B
            if (enc_phase && !bit_last_o) begin
                bit_idx_o <= bit_idx_o + 1'b1;
            end else begin
                bit_idx_o <= '0;
            end

            // Moves only on a sample the sink took, wraps after 63
            if (phase_i == MAP_OUT) begin
                if (out_accept_i) begin
                    sc_idx_o <= sc_idx_o + 1'b1;
                end
            end else begin
                sc_idx_o <= '0;
            end

            // DATA bit done after its B output, kept across symbols
            if (phase_i == IDLE) begin
                psdu_bit_cnt_o <= '0;
            end else if (phase_i == DATA_ENC && bit_idx_o[0]) begin
                psdu_bit_cnt_o <= psdu_bit_cnt_o + 1'b1;
            end
        end
    end

endmodule

//--- verilog/scram_conv_enc.sv
//////////////////////////////////////////////////////////////////////
// DATA scrambler, SIGNAL/SERVICE/PSDU/tail/pad bit source
// Rate 1/2 convolutional encoder, generators 133 and 171
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module scram_conv_enc
    import dot11_tx_pkg::*;
(
    input  logic               clk,
    input  logic               reset1,
    input  tx_phase_e          phase_i,
    input  logic [5:0]         bit_idx_i,
    input  logic [14:0]        data_bit_cnt_i,
    input  logic [14:0]        psdu_bits_i,
    input  plcp_word_u         mem_data_i,
    input  logic [SCRAM_W-1:0] init_data_scram_i,
    output logic               coded_bit_o,
    output logic [5:0]         coded_idx_o
);

    logic [SCRAM_W-1:0] scram_q;
    logic [5:0]         enc_q;
    logic [15:0]        cnt;
    logic [15:0]        psdu_end;
    logic [15:0]        tail_end;
    logic [5:0]         psdu_off;
    logic               src_bit;
    logic               in_tail;
    logic               scram_fb;
    logic               enc_in;
    logic               out_a;
    logic               out_b;

    assign cnt      = {1'b0, data_bit_cnt_i};
    assign psdu_end = 16'(SERVICE_BITS) + {1'b0, psdu_bits_i};
    assign tail_end = psdu_end + 16'(TAIL_BITS);
    assign psdu_off = data_bit_cnt_i[5:0] - 6'(SERVICE_BITS);

    //////////////////////////////////////////////////////////////////////
    // Bit source
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        src_bit = 1'b0;
        in_tail = 1'b0;
        if (phase_i == SIGNAL_ENC) begin
            // 24 header bits, each feeds two coded bits
            src_bit = mem_data_i.raw[bit_idx_i[5:1]];
        end else begin
            // SERVICE, tail and pad sources are zero
            if (cnt >= 16'(SERVICE_BITS) && cnt < psdu_end) begin
                src_bit = mem_data_i.raw[psdu_off];
            end
            in_tail = (cnt >= psdu_end) && (cnt < tail_end);
        end
    end

    // Tail stays zero so the encoder flushes to the all-zero state
    assign scram_fb = scram_q[6] ^ scram_q[3];
    assign enc_in   = (phase_i == DATA_ENC && !in_tail) ? (src_bit ^ scram_fb) : src_bit;

    // enc_q[0] is the previous input bit
    assign out_a = enc_in ^ enc_q[1] ^ enc_q[2] ^ enc_q[4] ^ enc_q[5];
    assign out_b = enc_in ^ enc_q[0] ^ enc_q[1] ^ enc_q[2] ^ enc_q[5];

    assign coded_bit_o = bit_idx_i[0] ? out_b : out_a;
    assign coded_idx_o = bit_idx_i;

    always_ff @(posedge clk) begin
        if (reset1) begin
            scram_q <= '0;
            enc_q   <= '0;
        end else begin
            case (phase_i)
                SIGNAL_ENC: begin
                    // SERVICE starts from the seed
                    scram_q <= init_data_scram_i;
                    if (bit_idx_i == 6'(N_CBPS - 1)) begin
                        enc_q <= '0;
                    end else if (bit_idx_i[0]) begin
                        enc_q <= {enc_q[4:0], enc_in};
                    end
                end
                DATA_ENC: begin
                    // Encoder state carries over symbol boundaries
                    if (bit_idx_i[0]) begin
                        enc_q <= {enc_q[4:0], enc_in};
                        if (!in_tail) begin
                            scram_q <= {scram_q[5:0], scram_fb};
                        end
                    end
                end
                IDLE, FETCH_HDR: begin
                    enc_q <= '0;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- verilog/interleave_buffer.sv
//////////////////////////////////////////////////////////////////////
// BPSK interleaver write address and 48 bit coded bit buffer
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module interleave_buffer
    import dot11_tx_pkg::*;
(
    input  logic       clk,
    input  logic       wr_en_i,
    input  logic       coded_bit_i,
    input  logic [5:0] coded_idx_i,
    input  logic [5:0] rd_idx_i,
    output logic       bit_o
);

    logic [N_CBPS-1:0] bits_q;
    logic [5:0]        wr_pos;

    // 3 * (k mod 16) + k / 16
    // Second permutation is the identity for one bit per carrier
    assign wr_pos = 6'(coded_idx_i[3:0]) * 6'd3 + 6'(coded_idx_i[5:4]);

    // Whole symbol is rewritten before every read pass
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            bits_q[wr_pos] <= coded_bit_i;
        end
    end

    // Mapper looks up the bit in the same cycle
    assign bit_o = bits_q[rd_idx_i];

endmodule

//--- verilog/subcarrier_mapper.sv
//////////////////////////////////////////////////////////////////////
// BPSK mapper, pilot scrambler and pilot polarity, DC and sidebands
// Registered IQ output with valid/ready hold
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module subcarrier_mapper
    import dot11_tx_pkg::*;
(
    input  logic               clk,
    input  logic               reset1,
    input  tx_phase_e          phase_i,
    input  logic [5:0]         sc_idx_i,
    input  logic               iq_ready_i,
    input  logic               data_bit_i,
    input  logic [SCRAM_W-1:0] init_pilot_scram_i,
    output logic [5:0]         rd_idx_o,
    output logic               iq_valid_o,
    output logic [IQ_W-1:0]    iq_i_o,
    output logic [IQ_W-1:0]    iq_q_o,
    output logic               out_accept_o
);

    localparam logic [IQ_W-1:0] NEG_AMP = ~PILOT_AMP + 1'b1;

    logic [SCRAM_W-1:0] pilot_scram_q;
    logic               data_sym_q;
    logic               pilot_inv;
    logic               sym_end;
    logic               sc_load;
    logic [5:0]         ld_idx;
    logic [IQ_W-1:0]    smp_i;

    assign out_accept_o = iq_valid_o & iq_ready_i;
    assign sym_end      = out_accept_o && (sc_idx_i == 6'(N_SC - 1));

    // Register holds sc_idx_i, so the next load is one index ahead
    assign ld_idx  = sc_idx_i + {5'd0, iq_valid_o};
    assign sc_load = (phase_i == MAP_OUT) && (!iq_valid_o || (out_accept_o && !sym_end));

    // SIGNAL pilots never inverted
    assign pilot_inv = data_sym_q & (pilot_scram_q[6] ^ pilot_scram_q[3]);

    //////////////////////////////////////////////////////////////////////
    // Subcarrier classification
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        rd_idx_o = '0;
        smp_i    = '0;
        if (ld_idx == 6'd0 || (ld_idx >= 6'd27 && ld_idx <= 6'd37)) begin
            // DC and sideband nulls
            smp_i = '0;
        end else if (ld_idx == 6'd7 || ld_idx == 6'd43 || ld_idx == 6'd57) begin
            smp_i = pilot_inv ? NEG_AMP : PILOT_AMP;
        end else if (ld_idx == 6'd21) begin
            smp_i = pilot_inv ? PILOT_AMP : NEG_AMP;
        end else begin
            // Positive carriers take the upper half of the buffer
            if (ld_idx < 6'd7) begin
                rd_idx_o = ld_idx + 6'd23;
            end else if (ld_idx < 6'd21) begin
                rd_idx_o = ld_idx + 6'd22;
            end else if (ld_idx < 6'd27) begin
                rd_idx_o = ld_idx + 6'd21;
            end else if (ld_idx < 6'd43) begin
                rd_idx_o = ld_idx - 6'd38;
            end else if (ld_idx < 6'd57) begin
                rd_idx_o = ld_idx - 6'd39;
            end else begin
                rd_idx_o = ld_idx - 6'd40;
            end
            smp_i = data_bit_i ? PILOT_AMP : NEG_AMP;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pilot scrambler and output handshake
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset1) begin
            pilot_scram_q <= '0;
            data_sym_q    <= 1'b0;
            iq_valid_o    <= 1'b0;
        end else begin
            // Seed held through SIGNAL, first DATA symbol uses it
            if (phase_i == SIGNAL_ENC) begin
                pilot_scram_q <= init_pilot_scram_i;
                data_sym_q    <= 1'b0;
            end else if (data_sym_q && sym_end) begin
                pilot_scram_q <= {pilot_scram_q[5:0], pilot_scram_q[6] ^ pilot_scram_q[3]};
            end
            if (phase_i == DATA_ENC) begin
                data_sym_q <= 1'b1;
            end

            if (sc_load) begin
                iq_valid_o <= 1'b1;
            end else if (out_accept_o) begin
                iq_valid_o <= 1'b0;
            end
        end
    end

    // Values stay put while the sink stalls
    always_ff @(posedge clk) begin
        if (sc_load) begin
            iq_i_o <= smp_i;
            iq_q_o <= '0;
        end
    end

endmodule

//--- verilog/dot11_tx_top.sv
//////////////////////////////////////////////////////////////////////
// 802.11a 6 Mbps transmit baseband top level
// FSM, counters, encoder, interleaver buffer and subcarrier mapper
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module dot11_tx_top
    import dot11_tx_pkg::*;
#(
    parameter int MEM_ADDR_W = dot11_tx_pkg::MEM_ADDR_W
) (
    input  logic                  clk,
    input  logic                  reset1,
    input  logic                  tx_start_i,
    output logic                  tx_started_o,
    output logic                  tx_done_o,
    input  logic [SCRAM_W-1:0]    init_pilot_scram_i,
    input  logic [SCRAM_W-1:0]    init_data_scram_i,
    output logic [MEM_ADDR_W-1:0] mem_addr_o,
    input  plcp_word_u            mem_data_i,
    input  logic                  iq_ready_i,
    output logic                  iq_valid_o,
    output logic [IQ_W-1:0]       iq_i_o,
    output logic [IQ_W-1:0]       iq_q_o
);

    tx_phase_e   phase;
    logic [14:0] psdu_bits;
    logic [14:0] psdu_bit_cnt;
    logic [5:0]  bit_idx;
    logic [5:0]  sc_idx;
    logic        bit_last;
    logic        sc_last;
    logic        out_accept;
    logic        coded_bit;
    logic [5:0]  coded_idx;
    logic        enc_wr_en;
    logic [5:0]  rd_idx;
    logic        buf_bit;

    // Buffer is written only while bits are being encoded
    assign enc_wr_en = (phase == SIGNAL_ENC) || (phase == DATA_ENC);

    tx_ctrl_fsm #(
        .MEM_ADDR_W(MEM_ADDR_W)
    ) u_ctrl (
        .clk           (clk),
        .reset1        (reset1),
        .tx_start_i    (tx_start_i),
        .hdr_i         (mem_data_i),
        .bit_last_i    (bit_last),
        .sc_last_i     (sc_last),
        .out_accept_i  (out_accept),
        .psdu_bit_cnt_i(psdu_bit_cnt),
        .phase_o       (phase),
        .psdu_bits_o   (psdu_bits),
        .mem_addr_o    (mem_addr_o),
        .tx_started_o  (tx_started_o),
        .tx_done_o     (tx_done_o)
    );

    symbol_counter u_cnt (
        .clk           (clk),
        .reset1        (reset1),
        .phase_i       (phase),
        .out_accept_i  (out_accept),
        .bit_idx_o     (bit_idx),
        .sc_idx_o      (sc_idx),
        .bit_last_o    (bit_last),
        .sc_last_o     (sc_last),
        .psdu_bit_cnt_o(psdu_bit_cnt)
    );

    scram_conv_enc u_enc (
        .clk              (clk),
        .reset1           (reset1),
        .phase_i          (phase),
        .bit_idx_i        (bit_idx),
        .data_bit_cnt_i   (psdu_bit_cnt),
        .psdu_bits_i      (psdu_bits),
        .mem_data_i       (mem_data_i),
        .init_data_scram_i(init_data_scram_i),
        .coded_bit_o      (coded_bit),
        .coded_idx_o      (coded_idx)
    );

    interleave_buffer u_ilv (
        .clk        (clk),
        .wr_en_i    (enc_wr_en),
        .coded_bit_i(coded_bit),
        .coded_idx_i(coded_idx),
        .rd_idx_i   (rd_idx),
        .bit_o      (buf_bit)
    );

    subcarrier_mapper u_map (
        .clk               (clk),
        .reset1            (reset1),
        .phase_i           (phase),
        .sc_idx_i          (sc_idx),
        .iq_ready_i        (iq_ready_i),
        .data_bit_i        (buf_bit),
        .init_pilot_scram_i(init_pilot_scram_i),
        .rd_idx_o          (rd_idx),
        .iq_valid_o        (iq_valid_o),
        .iq_i_o            (iq_i_o),
        .iq_q_o            (iq_q_o),
        .out_accept_o      (out_accept)
    );

endmodule

//--- tb/tx_ref_model.svh
//////////////////////////////////////////////////////////////////////
// Reference model of the 6 Mbps transmit chain
// Expected I values of the SIGNAL and DATA symbols of one packet
//////////////////////////////////////////////////////////////////////
`ifndef TX_REF_MODEL_SVH
`define TX_REF_MODEL_SVH

function automatic logic [15:0] bpsk_level(input logic b);
    return b ? 16'h4000 : 16'hc000;
endfunction

// Encode, interleave and map 24 source bits, append 64 samples
task automatic add_symbol(input logic [23:0] src, inout logic [6:0] sr, input logic inv);
    logic [47:0] coded;
    logic [47:0] ilv;
    int          hi;
    int          lo;
    // sr[6] is the newest input, generators 133 and 171 octal
    for (int j = 0; j < 24; j++) begin
        sr = {src[5'(j)], sr[6:1]};
        coded[6'(2*j)]   = ^(sr & 7'o133);
        coded[6'(2*j+1)] = ^(sr & 7'o171);
    end
    for (int k = 0; k < 48; k++) begin
        ilv[6'(3*(k%16) + k/16)] = coded[6'(k)];
    end
    hi = 24;
    lo = 0;
    for (int c = 0; c < 64; c++) begin
        if (c == 0 || (c >= 27 && c <= 37)) begin
            exp_mem[exp_total] = 16'h0000;
        end else if (c == 7 || c == 43 || c == 57) begin
            exp_mem[exp_total] = bpsk_level(!inv);
        end else if (c == 21) begin
            exp_mem[exp_total] = bpsk_level(inv);
        end else if (c < 27) begin
            exp_mem[exp_total] = bpsk_level(ilv[6'(hi)]);
            hi++;
        end else begin
            exp_mem[exp_total] = bpsk_level(ilv[6'(lo)]);
            lo++;
        end
        exp_total = exp_total + 1'b1;
    end
endtask

// SIGNAL from word 0, then SERVICE, PSDU, tail and pad
task automatic build_packet(input int len, input logic [6:0] dseed, input logic [6:0] pseed);
    logic [6:0]  sr;
    logic [6:0]  ds;
    logic [6:0]  ps;
    logic [23:0] src;
    logic        x;
    logic        fb;
    int          n_bits;
    int          i;
    sr = '0;
    add_symbol(mem[0][23:0], sr, 1'b0);
    sr     = '0;
    ds     = dseed;
    ps     = pseed;
    n_bits = 22 + 8 * len;
    i      = 0;
    while (i < n_bits) begin
        for (int j = 0; j < 24; j++) begin
            x = 1'b0;
            if (i >= 16 && i < 16 + 8 * len) begin
                x = mem[10'(1 + (i - 16) / 64)][6'((i - 16) % 64)];
            end
            // Tail bits pass unscrambled and hold the scrambler
            if (i < 16 + 8 * len || i >= n_bits) begin
                fb = ds[6] ^ ds[3];
                x  = x ^ fb;
                ds = {ds[5:0], fb};
            end
            src[5'(j)] = x;
            i++;
        end
        fb = ps[6] ^ ps[3];
        add_symbol(src, sr, fb);
        ps = {ps[5:0], fb};
    end
endtask

`endif

//--- tb/tb_dot11_tx.sv
//////////////////////////////////////////////////////////////////////
// Testbench of the OFDM transmit baseband
// Memory model, random back-pressure, assertions and reporting
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_dot11_tx
    import dot11_tx_pkg::*;
();

    logic        clk;
    logic        reset1;
    logic        tx_start_i;
    logic        tx_started_o;
    logic        tx_done_o;
    logic [6:0]  init_pilot_scram_i;
    logic [6:0]  init_data_scram_i;
    logic [9:0]  mem_addr_o;
    plcp_word_u  mem_data_i = '0;
    logic        iq_ready_i = 1'b1;
    logic        iq_valid_o;
    logic [15:0] iq_i_o;
    logic [15:0] iq_q_o;

    logic [63:0] mem [0:1023];
    logic [15:0] exp_mem [0:2047];
    logic [15:0] got_mem [0:2047];
    logic [10:0] exp_total = '0;
    logic [10:0] acc_idx = '0;
    logic [10:0] base2;
    logic [10:0] base3;
    int          seed = 32'hdf77;
    int          done_cnt = 0;
    int          started_cnt = 0;
    int          err_cnt = 0;
    int          fail_tests = 0;
    int          cyc = 0;
    int          wd_deadline = 2000;
    logic        armed = 1'b0;
    logic        rand_ready = 1'b0;

    `include "tx_ref_model.svh"

    dot11_tx_top #(.MEM_ADDR_W(10)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // One cycle read latency
    always @(posedge clk) begin
        mem_data_i.raw <= mem[mem_addr_o];
    end

    always @(posedge clk) begin : ready_gen
        int r;
        r = $random(seed);
        iq_ready_i <= rand_ready ? r[0] : 1'b1;
    end

    always @(posedge clk) begin
        if (iq_valid_o && iq_ready_i) begin
            got_mem[acc_idx] <= iq_i_o;
            acc_idx          <= acc_idx + 1'b1;
        end
        if (tx_done_o) begin
            done_cnt <= done_cnt + 1;
        end
        if (tx_started_o) begin
            started_cnt <= started_cnt + 1;
        end
        cyc <= cyc + 1;
    end

    always @(posedge clk) begin
        if (cyc > wd_deadline) begin
            $display("Timeout, tx_done_o not seen after %0d cycles", cyc);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////
    idle_chk: assert property (@(posedge clk) disable iff (reset1)
        !armed |-> !iq_valid_o && !tx_started_o && !tx_done_o)
        else begin
            err_cnt++;
            $display("MISMATCH at %0t: output active before tx_start_i", $time);
        end

    // Header word has arrived two cycles after the start request
    start_chk: assert property (@(posedge clk) disable iff (reset1)
        tx_started_o |-> $past(tx_start_i, 2))
        else begin
            err_cnt++;
            $display("MISMATCH at %0t: tx_started_o not two cycles after tx_start_i", $time);
        end

    value_chk: assert property (@(posedge clk) disable iff (reset1)
        iq_valid_o && iq_ready_i |-> iq_i_o == exp_mem[acc_idx])
        else begin
            err_cnt++;
            $display("MISMATCH at %0t: sample %0d I %h expected %h", $time,
                     $sampled(acc_idx), $sampled(iq_i_o), $sampled(exp_mem[acc_idx]));
        end

    // DC and sideband carriers
    null_chk: assert property (@(posedge clk) disable iff (reset1)
        iq_valid_o && iq_ready_i && (acc_idx[5:0] == 6'd0 ||
        (acc_idx[5:0] >= 6'd27 && acc_idx[5:0] <= 6'd37)) |-> iq_i_o == 16'h0)
        else begin
            err_cnt++;
            $display("MISMATCH at %0t: null carrier %0d not zero", $time, $sampled(acc_idx));
        end

    q_chk: assert property (@(posedge clk) disable iff (reset1)
        iq_valid_o |-> iq_q_o == 16'h0)
        else begin
            err_cnt++;
            $display("MISMATCH at %0t: Q is %h", $time, $sampled(iq_q_o));
        end

    hold_chk: assert property (@(posedge clk) disable iff (reset1)
        iq_valid_o && !iq_ready_i |=> iq_valid_o && $stable(iq_i_o) && $stable(iq_q_o))
        else begin
            err_cnt++;
            $display("MISMATCH at %0t: held sample changed", $time);
        end

    done_chk: assert property (@(posedge clk) disable iff (reset1)
        tx_done_o |-> acc_idx == exp_total)
        else begin
            err_cnt++;
            $display("MISMATCH at %0t: done after %0d samples, expected %0d", $time,
                     $sampled(acc_idx), $sampled(exp_total));
        end

    task automatic run_test(input int num, input int len, input logic [6:0] dseed,
                            input logic [6:0] pseed, input logic rnd, input int fseed);
        int          errs_before;
        int          done_before;
        int          started_before;
        int          fill;
        int          n_sym;
        logic [10:0] first;
        logic [63:0] hdr;
        errs_before = err_cnt;
        fill        = fseed;
        first       = exp_total;
        for (int a = 0; a < 1024; a++) begin
            mem[a] = {$random(fill), $random(fill)};
        end
        // Rate 6 Mbps, length, even parity, zero SIGNAL tail
        hdr        = mem[0];
        hdr[23:0]  = '0;
        hdr[3:0]   = 4'b1011;
        hdr[16:5]  = 12'(len);
        hdr[17]    = ^hdr[16:0];
        mem[0]     = hdr;
        build_packet(len, dseed, pseed);
        n_sym          = 32'(exp_total - first) / 64;
        done_before    = done_cnt;
        started_before = started_cnt;
        wd_deadline    = cyc + 4 * n_sym * (48 + 64 * 4) + 100;
        @(posedge clk);
        tx_start_i         <= 1'b1;
        armed              <= 1'b1;
        rand_ready         <= rnd;
        init_data_scram_i  <= dseed;
        init_pilot_scram_i <= pseed;
        @(posedge clk);
        tx_start_i <= 1'b0;
        while (done_cnt == done_before) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        wd_deadline = cyc + 2000;
        assert (started_cnt - started_before == 1) else begin
            err_cnt++;
            $display("Test %0d saw %0d start pulses instead of one", num,
                     started_cnt - started_before);
        end
        assert (done_cnt - done_before == 1) else begin
            err_cnt++;
            $display("Test %0d saw %0d done pulses instead of one", num, done_cnt - done_before);
        end
        assert (32'(acc_idx - first) / 64 == 1 + (22 + 8 * len + 23) / 24) else begin
            err_cnt++;
            $display("Test %0d sent %0d symbols, wrong count", num, 32'(acc_idx - first) / 64);
        end
        if (err_cnt != errs_before) begin
            fail_tests++;
        end
        $display("test %0d len %0d ready %s: %0d symbols, %0d errors", num, len,
                 rnd ? "random" : "high", n_sym, err_cnt - errs_before);
    endtask

    initial begin
        reset1             = 1'b1;
        tx_start_i         = 1'b0;
        init_pilot_scram_i = '0;
        init_data_scram_i  = '0;
        repeat (2) @(posedge clk);
        reset1 <= 1'b0;
        repeat (6) @(posedge clk);
        run_test(1, 5, 7'h5d, 7'h7f, 1'b0, 32'hdf77);
        base2 = exp_total;
        run_test(2, 20, 7'h2b, 7'h35, 1'b0, 32'hdf78);
        base3 = exp_total;
        run_test(3, 20, 7'h2b, 7'h35, 1'b1, 32'hdf78);
        // Stalled run against the run with ready held high
        for (int k = 0; k < 32'(base3 - base2); k++) begin
            assert (got_mem[base2 + 11'(k)] == got_mem[base3 + 11'(k)]) else begin
                err_cnt++;
                $display("MISMATCH at %0t: stalled sample %0d differs", $time, k);
            end
        end
        $display("3 tests, %0d failed, %0d errors", fail_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+tb
verilog/dot11_tx_pkg.sv
verilog/tx_ctrl_fsm.sv
verilog/symbol_counter.sv
verilog/scram_conv_enc.sv
verilog/interleave_buffer.sv
verilog/subcarrier_mapper.sv
verilog/dot11_tx_top.sv
tb/tb_dot11_tx.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_dot11_tx -o tb_sim
./obj_dir/tb_sim > sim.log
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
else
    exit 1
fi
